//--- design/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  exec_pkg::alu_op_t alu_op,
    input  exec_pkg::data_t   src1,
    input  exec_pkg::data_t   src2,
    output exec_pkg::data_t   result
);

    logic            do_sub;
    logic [32:0]     sum;
    exec_pkg::data_t adder_b;
    exec_pkg::data_t slt_res;
    exec_pkg::data_t sltu_res;
    exec_pkg::data_t sll_res;
    exec_pkg::data_t srl_res;
    exec_pkg::data_t sra_res;
    logic [4:0]      shamt;

    // compares share the subtracter
    assign do_sub = alu_op[exec_pkg::ALU_SUB]
                  | alu_op[exec_pkg::ALU_SLT]
                  | alu_op[exec_pkg::ALU_SLTU];

    assign adder_b = do_sub ? ~src2 : src2;
    assign sum     = {1'b0, src1} + {1'b0, adder_b} + {32'd0, do_sub};

    assign slt_res  = {31'd0, (src1[31] & ~src2[31])
                            | (~(src1[31] ^ src2[31]) & sum[31])};
    // no carry out means borrow
    assign sltu_res = {31'd0, ~sum[32]};

    assign shamt   = src2[4:0];
    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = $signed(src1) >>> shamt;

    assign result = ({32{alu_op[exec_pkg::ALU_ADD] | alu_op[exec_pkg::ALU_SUB]}} & sum[31:0])
                  | ({32{alu_op[exec_pkg::ALU_SLT]}}  & slt_res)
                  | ({32{alu_op[exec_pkg::ALU_SLTU]}} & sltu_res)
                  | ({32{alu_op[exec_pkg::ALU_AND]}}  & (src1 & src2))
                  | ({32{alu_op[exec_pkg::ALU_NOR]}}  & ~(src1 | src2))
                  | ({32{alu_op[exec_pkg::ALU_OR]}}   & (src1 | src2))
                  | ({32{alu_op[exec_pkg::ALU_XOR]}}  & (src1 ^ src2))
                  | ({32{alu_op[exec_pkg::ALU_SLL]}}  & sll_res)
                  | ({32{alu_op[exec_pkg::ALU_SRL]}}  & srl_res)
                  | ({32{alu_op[exec_pkg::ALU_SRA]}}  & sra_res)
                  | ({32{alu_op[exec_pkg::ALU_LUI]}}  & src2);

endmodule

`default_nettype wire

//--- design/div.sv
`timescale 1ns/100ps
`default_nettype none

module div (
    input  logic            clk,
    input  logic            resetn,
    input  logic            abort,
    input  logic            start,
    input  logic            div_signed,
    input  exec_pkg::data_t x,
    input  exec_pkg::data_t y,
    output exec_pkg::data_t quotient,
    output exec_pkg::data_t remainder,
    output logic            complete
);

    exec_pkg::div_state_t state;
    logic [$clog2(exec_pkg::DIV_ITER)-1:0] cnt;
    exec_pkg::data_t rem_q;
    exec_pkg::data_t quo_q;
    exec_pkg::data_t divisor_q;
    logic            q_neg;
    logic            r_neg;
    logic [32:0]     shifted;
    logic [32:0]     diff;

    // one restoring step per cycle
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (!resetn || abort) begin
            state <= exec_pkg::DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exec_pkg::DIV_IDLE: begin
                    if (start) begin
                        state <= exec_pkg::DIV_BUSY;
                        cnt   <= '0;
                    end
                end
                exec_pkg::DIV_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == exec_pkg::DIV_ITER - 1) begin
                        state <= exec_pkg::DIV_DONE;
                    end
                end
                default: state <= exec_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == exec_pkg::DIV_IDLE && start) begin
            rem_q     <= '0;
            quo_q     <= (div_signed && x[31]) ? -x : x;
            divisor_q <= (div_signed && y[31]) ? -y : y;
            q_neg     <= div_signed & (x[31] ^ y[31]);
            r_neg     <= div_signed & x[31];
        end else if (state == exec_pkg::DIV_BUSY) begin
            rem_q <= diff[32] ? shifted[31:0] : diff[31:0];
            quo_q <= {quo_q[30:0], ~diff[32]};
        end
    end

    assign quotient  = q_neg ? -quo_q : quo_q;
    assign remainder = r_neg ? -rem_q : rem_q;
    assign complete  = (state == exec_pkg::DIV_DONE);

    // stage must not retrigger a running division
    assert property (@(posedge clk) disable iff (!resetn)
        (state == exec_pkg::DIV_BUSY) |-> !start);

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  id_valid,
    input  stage_pkg::id_to_ex_t  id_in,
    output logic                  ex_allowin,
    input  logic                  mem_allowin,
    output logic                  mem_valid,
    output stage_pkg::ex_to_mem_t mem_out,
    output stage_pkg::ex_fwd_t    fwd,
    output logic [63:0]           mul_result,
    output logic                  data_req,
    output logic                  data_wr,
    output logic [1:0]            data_size,
    output exec_pkg::strb_t       data_wstrb,
    output exec_pkg::data_t       data_addr,
    output exec_pkg::data_t       data_wdata,
    input  logic                  data_addr_ok,
    input  logic                  flush,
    input  logic                  mem_excep
);

    stage_pkg::id_to_ex_t id_q;
    logic            ex_valid;
    logic            ready_go;
    logic            transfer_in;
    logic            is_load;
    logic            is_store;
    logic            is_div;
    logic            mem_wait;
    logic            ale;
    logic            div_start;
    logic            div_complete;
    logic            div_issued_q;
    logic            div_done_q;
    exec_pkg::data_t alu_result;
    exec_pkg::data_t div_quo;
    exec_pkg::data_t div_rem;
    exec_pkg::data_t final_result;
    exec_pkg::mem_op_t op;

    assign transfer_in = id_valid & ex_allowin;
    assign op          = id_q.mem_op;
    assign is_load     = |op[exec_pkg::MEM_LD_W:exec_pkg::MEM_LD_B];
    assign is_store    = |op[exec_pkg::MEM_ST_W:exec_pkg::MEM_ST_B];
    assign is_div      = id_q.res_sel[exec_pkg::RES_DIV];

    assign ready_go   = (data_req & data_addr_ok)
                      | (is_div & (div_complete | div_done_q))
                      | ~(mem_wait | is_div);
    assign ex_allowin = ~ex_valid | (ready_go & mem_allowin) | flush;
    assign mem_valid  = ex_valid & ready_go & ~flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (transfer_in) begin
            id_q <= id_in;
        end
    end

    alu u_alu (
        .alu_op (id_q.alu_op),
        .src1   (id_q.src1),
        .src2   (id_q.src2),
        .result (alu_result)
    );

    mul u_mul (
        .clk        (clk),
        .resetn     (resetn),
        .mul_signed (id_q.mul_signed),
        .x          (id_q.src1),
        .y          (id_q.src2),
        .result     (mul_result)
    );

    // issued blocks a restart and done keeps the stage ready until handoff
    always_ff @(posedge clk) begin
        if (!resetn || flush || transfer_in) begin
            div_issued_q <= 1'b0;
            div_done_q   <= 1'b0;
        end else begin
            if (div_start) begin
                div_issued_q <= 1'b1;
            end
            if (div_complete) begin
                div_done_q <= 1'b1;
            end
        end
    end

    assign div_start = ex_valid & is_div & ~div_issued_q;

    div u_div (
        .clk        (clk),
        .resetn     (resetn),
        .abort      (flush),
        .start      (div_start),
        .div_signed (id_q.div_signed),
        .x          (id_q.src1),
        .y          (id_q.src2),
        .quotient   (div_quo),
        .remainder  (div_rem),
        .complete   (div_complete)
    );

    assign final_result = is_div ? (id_q.div_r ? div_rem : div_quo) : alu_result;

    assign ale = ex_valid
               & (((op[exec_pkg::MEM_LD_H] | op[exec_pkg::MEM_LD_HU] | op[exec_pkg::MEM_ST_H])
                   & alu_result[0])
                 | ((op[exec_pkg::MEM_LD_W] | op[exec_pkg::MEM_ST_W]) & (|alu_result[1:0])));

    assign mem_wait = (is_load | is_store) & ~mem_excep & ~flush & ~ale;

    assign data_req  = mem_wait & ex_valid & mem_allowin;
    assign data_wr   = is_store;
    assign data_addr = alu_result;
    assign data_size = {op[exec_pkg::MEM_LD_W] | op[exec_pkg::MEM_ST_W],
                        op[exec_pkg::MEM_LD_H] | op[exec_pkg::MEM_LD_HU] | op[exec_pkg::MEM_ST_H]};

    always_comb begin
        data_wstrb = 4'b0000;
        data_wdata = id_q.rkd_value;
        if (op[exec_pkg::MEM_ST_B]) begin
            data_wstrb = 4'b0001 << alu_result[1:0];
            data_wdata = {4{id_q.rkd_value[7:0]}};
        end else if (op[exec_pkg::MEM_ST_H]) begin
            data_wstrb = alu_result[1] ? 4'b1100 : 4'b0011;
            data_wdata = {2{id_q.rkd_value[15:0]}};
        end else if (op[exec_pkg::MEM_ST_W]) begin
            data_wstrb = 4'b1111;
        end
    end

    always_comb begin
        mem_out.rf_we         = id_q.rf_we;
        mem_out.rf_waddr      = id_q.rf_waddr;
        mem_out.pc            = id_q.pc;
        mem_out.result        = final_result;
        mem_out.ld_op         = op[exec_pkg::MEM_LD_W:exec_pkg::MEM_LD_B];
        mem_out.mem_wait      = mem_wait;
        mem_out.res_sel       = id_q.res_sel;
        mem_out.mul_h         = id_q.mul_h;
        mem_out.excep.adef    = id_q.excep.adef;
        mem_out.excep.syscall = id_q.excep.syscall;
        mem_out.excep.brk     = id_q.excep.brk;
        mem_out.excep.ine     = id_q.excep.ine;
        mem_out.excep.ertn    = id_q.excep.ertn;
        mem_out.excep.ale     = ale;
    end

    // loads and multiplies only have their value in a later stage
    assign fwd.wait_late = (is_load | id_q.res_sel[exec_pkg::RES_MUL]) & ex_valid;
    assign fwd.we        = id_q.rf_we & ex_valid;
    assign fwd.waddr     = id_q.rf_waddr;
    assign fwd.result    = final_result;

    // a request not yet accepted keeps its address and data
    assert property (@(posedge clk) disable iff (!resetn)
        data_req && !data_addr_ok |=> $stable(data_addr) && $stable(data_wdata));

    // back-pressure freezes what the memory stage sees
    assert property (@(posedge clk) disable iff (!resetn)
        mem_valid && !mem_allowin |=> $stable(mem_out.pc) && $stable(mem_out.result));

endmodule

`default_nettype wire

//--- design/ex_top.sv
`timescale 1ns/100ps
`default_nettype none

module ex_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  id_valid,
    input  stage_pkg::id_to_ex_t  id_in,
    output logic                  ex_allowin,
    input  logic                  mem_allowin,
    output logic                  mem_valid,
    output stage_pkg::ex_to_mem_t mem_out,
    output stage_pkg::ex_fwd_t    fwd,
    output logic [63:0]           mul_result,
    output logic                  data_req,
    output logic                  data_wr,
    output logic [1:0]            data_size,
    output exec_pkg::strb_t       data_wstrb,
    output exec_pkg::data_t       data_addr,
    output exec_pkg::data_t       data_wdata,
    input  logic                  data_addr_ok,
    input  logic                  flush,
    input  logic                  mem_excep
);

    ex_stage u_ex_stage (
        .clk          (clk),
        .resetn       (resetn),
        .id_valid     (id_valid),
        .id_in        (id_in),
        .ex_allowin   (ex_allowin),
        .mem_allowin  (mem_allowin),
        .mem_valid    (mem_valid),
        .mem_out      (mem_out),
        .fwd          (fwd),
        .mul_result   (mul_result),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .flush        (flush),
        .mem_excep    (mem_excep)
    );

endmodule

`default_nettype wire

//--- design/exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;
    typedef logic [7:0]  mem_op_t;
    typedef logic [2:0]  res_sel_t;
    typedef logic [3:0]  strb_t;

    // one-hot alu operation bits
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // one-hot memory operation bits with the loads in the low five
    localparam int MEM_LD_B  = 0;
    localparam int MEM_LD_BU = 1;
    localparam int MEM_LD_H  = 2;
    localparam int MEM_LD_HU = 3;
    localparam int MEM_LD_W  = 4;
    localparam int MEM_ST_B  = 5;
    localparam int MEM_ST_H  = 6;
    localparam int MEM_ST_W  = 7;

    localparam int RES_MEM = 0;
    localparam int RES_MUL = 1;
    localparam int RES_DIV = 2;

    localparam int DIV_ITER = 32;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

//--- design/mul.sv
`timescale 1ns/100ps
`default_nettype none

module mul (
    input  logic            clk,
    input  logic            resetn,
    input  logic            mul_signed,
    input  exec_pkg::data_t x,
    input  exec_pkg::data_t y,
    output logic [63:0]     result
);

    logic [32:0] x_ext;
    logic [32:0] y_ext;
    logic [65:0] product;

    // sign or zero extension makes one signed multiplier serve both
    assign x_ext = {mul_signed & x[31], x};
    assign y_ext = {mul_signed & y[31], y};

    assign product = $signed(x_ext) * $signed(y_ext);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
        end else begin
            result <= product[63:0];
        end
    end

endmodule

`default_nettype wire

//--- design/stage_pkg.sv
`default_nettype none

package stage_pkg;

    typedef struct packed {
        logic adef;
        logic syscall;
        logic brk;
        logic ine;
        logic ertn;
    } id_excep_t;

    // decode bits plus misaligned access
    typedef struct packed {
        logic adef;
        logic syscall;
        logic brk;
        logic ine;
        logic ertn;
        logic ale;
    } ex_excep_t;

    typedef struct packed {
        exec_pkg::alu_op_t   alu_op;
        exec_pkg::data_t     src1;
        exec_pkg::data_t     src2;
        exec_pkg::data_t     rkd_value;
        logic                rf_we;
        exec_pkg::reg_addr_t rf_waddr;
        exec_pkg::data_t     pc;
        exec_pkg::mem_op_t   mem_op;
        exec_pkg::res_sel_t  res_sel;
        logic                mul_signed;
        logic                mul_h;
        logic                div_signed;
        logic                div_r;
        id_excep_t           excep;
    } id_to_ex_t;

    typedef struct packed {
        logic                rf_we;
        exec_pkg::reg_addr_t rf_waddr;
        exec_pkg::data_t     pc;
        exec_pkg::data_t     result;
        // ld_w down to ld_b
        logic [4:0]          ld_op;
        logic                mem_wait;
        exec_pkg::res_sel_t  res_sel;
        logic                mul_h;
        ex_excep_t           excep;
    } ex_to_mem_t;

    typedef struct packed {
        logic                wait_late;
        logic                we;
        exec_pkg::reg_addr_t waddr;
        exec_pkg::data_t     result;
    } ex_fwd_t;

endpackage

`default_nettype wire

//--- flist.f
design/exec_pkg.sv
design/stage_pkg.sv
design/alu.sv
design/mul.sv
design/div.sv
design/ex_stage.sv
design/ex_top.sv
tb/tb_ex_top.sv

//--- tb/ex_vectors.mem
// columns: ctrl src1 src2 rkd_value expect_lo expect_hi
// ctrl: [11:0] alu_op [19:12] mem_op [22:20] res_sel [23] mul_signed [24] div_signed
// [25] div_r [26] flush [27] ale [31:28] strobe
00000001 00000005 00000003 00000000 00000008 00000000
00000002 00000003 00000005 00000000 fffffffe 00000000
00000004 ffffffff 00000001 00000000 00000001 00000000
00000008 ffffffff 00000001 00000000 00000000 00000000
00000010 f0f0f0f0 0ff00ff0 00000000 00f000f0 00000000
00000020 0000ffff 00ff0000 00000000 ff000000 00000000
00000040 12340000 00005678 00000000 12345678 00000000
00000080 aaaa5555 ffff0000 00000000 55555555 00000000
00000100 00000001 0000003f 00000000 80000000 00000000
00000200 80000000 00000004 00000000 08000000 00000000
00000400 80000000 00000004 00000000 f8000000 00000000
00000800 12345678 abcde000 00000000 abcde000 00000000
00110001 00001000 00000004 00000000 00001004 00000000
00101001 00001000 00000003 00000000 00001003 00000000
00108001 00001000 00000002 00000000 00001002 00000000
08104001 00001000 00000001 00000000 00001001 00000000
08110001 00001000 00000006 00000000 00001006 00000000
f0080001 00002000 00000000 11223344 00002000 00000000
20020001 00002000 00000001 000000a5 00002001 00000000
c0040001 00002000 00000002 0000beef 00002002 00000000
08040001 00002000 00000003 0000beef 00002003 00000000
80020001 00002000 00000003 12345678 00002003 00000000
00400000 00000064 00000007 00000000 0000000e 00000000
02400000 00000064 00000007 00000000 00000002 00000000
01400000 ffffff9c 00000007 00000000 fffffff2 00000000
03400000 ffffff9c 00000007 00000000 fffffffe 00000000
00000001 00000010 00000020 00000000 00000030 00000000
00a00000 ffffffff 00000002 00000000 fffffffe ffffffff
00200000 ffffffff 00000002 00000000 fffffffe 00000001
04000001 00000001 00000001 00000000 00000002 00000000
00a00000 12345678 00000010 00000000 23456780 00000001
00400000 ffffffff 00000010 00000000 0fffffff 00000000

//--- tb/tb_ex_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ex_top;

    localparam int MAX_VEC = 64;
    localparam int WORDS   = 6;

    logic                  clk;
    logic                  resetn;
    logic                  id_valid;
    stage_pkg::id_to_ex_t  id_in;
    logic                  ex_allowin;
    logic                  mem_allowin;
    logic                  mem_valid;
    stage_pkg::ex_to_mem_t mem_out;
    stage_pkg::ex_fwd_t    fwd;
    logic [63:0]           mul_result;
    logic                  data_req;
    logic                  data_wr;
    logic [1:0]            data_size;
    exec_pkg::strb_t       data_wstrb;
    exec_pkg::data_t       data_addr;
    exec_pkg::data_t       data_wdata;
    logic                  data_addr_ok;
    logic                  flush;
    logic                  mem_excep;

    logic [31:0] vec [0:MAX_VEC*WORDS-1];
    int          err_mark [0:MAX_VEC-1];
    integer      seed;
    int          nvec;
    int          nflag;
    int          cur_idx;
    int          held_idx;
    int          stall_idx;
    int          mul_idx;
    int          err_cnt;
    int          done_cnt;
    int          handed_cnt;
    int          flush_cnt;
    logic        held_valid;
    logic        req_seen;
    logic        req_done;
    logic        stall_q;
    logic        mul_pending;
    logic        in_xfer;
    logic        out_xfer;
    stage_pkg::ex_to_mem_t saved_out;

    ex_top DUT (
        .clk          (clk),
        .resetn       (resetn),
        .id_valid     (id_valid),
        .id_in        (id_in),
        .ex_allowin   (ex_allowin),
        .mem_allowin  (mem_allowin),
        .mem_valid    (mem_valid),
        .mem_out      (mem_out),
        .fwd          (fwd),
        .mul_result   (mul_result),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .flush        (flush),
        .mem_excep    (mem_excep)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] field(input int idx, input int w);
        return vec[idx*WORDS + w];
    endfunction

    function automatic logic [31:0] pc_of(input int idx);
        return 32'h1c00_0000 + idx * 4;
    endfunction

    // byte four times, halfword twice
    function automatic logic [31:0] store_data(input logic [7:0] op, input logic [31:0] rkd);
        if (op[exec_pkg::MEM_ST_B]) begin
            return {4{rkd[7:0]}};
        end
        if (op[exec_pkg::MEM_ST_H]) begin
            return {2{rkd[15:0]}};
        end
        return rkd;
    endfunction

    function automatic logic [1:0] size_of(input logic [7:0] op);
        if (op[exec_pkg::MEM_LD_W] || op[exec_pkg::MEM_ST_W]) begin
            return 2'd2;
        end
        if (op[exec_pkg::MEM_LD_H] || op[exec_pkg::MEM_LD_HU] || op[exec_pkg::MEM_ST_H]) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

    function automatic string kind_name(input logic [31:0] c);
        if (c[22]) begin
            return "div";
        end
        if (c[21]) begin
            return "mul";
        end
        if (|c[19:12]) begin
            return "load/store";
        end
        return "alu";
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("error: %s got %0h expected %0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_vector(input int idx);
        logic [31:0] c;
        c = field(idx, 0);
        $display("vector %0d %s: %s", idx, kind_name(c),
                 (err_cnt == err_mark[idx]) ? "pass" : "mismatch");
        done_cnt++;
    endtask

    task automatic drive_inputs();
        logic [31:0] c;
        logic [31:0] hc;
        c  = field(cur_idx, 0);
        hc = field(held_idx, 0);
        id_valid = (cur_idx < nvec);
        id_in    = '0;
        if (cur_idx < nvec) begin
            id_in.alu_op     = c[11:0];
            id_in.mem_op     = c[19:12];
            id_in.res_sel    = c[22:20];
            id_in.mul_signed = c[23];
            id_in.div_signed = c[24];
            id_in.div_r      = c[25];
            id_in.src1       = field(cur_idx, 1);
            id_in.src2       = field(cur_idx, 2);
            id_in.rkd_value  = field(cur_idx, 3);
            id_in.rf_we      = 1'b1;
            id_in.rf_waddr   = cur_idx[4:0];
            id_in.pc         = pc_of(cur_idx);
        end
        mem_allowin  = ($random(seed) & 3) != 0;
        data_addr_ok = ($random(seed) & 1) != 0;
        // flagged vectors are killed in their first held cycle
        flush = held_valid & hc[26];
    endtask

    task automatic sample_outputs();
        logic [31:0] c;
        c = field(held_idx, 0);
        in_xfer  = id_valid & ex_allowin;
        out_xfer = mem_valid & mem_allowin;
        check("fwd.we", fwd.we, held_valid);
        if (held_valid) begin
            check("fwd.wait_late", fwd.wait_late, (|c[16:12]) | c[21]);
            check("fwd.waddr", fwd.waddr, held_idx[4:0]);
            if (c[26] && mem_valid) begin
                $display("instruction %0d raised mem_valid despite its flush", held_idx);
                err_cnt++;
            end
        end else begin
            check("fwd.wait_late", fwd.wait_late, 1'b0);
        end
        if (mul_pending) begin
            check("mul_result", mul_result, {field(mul_idx, 5), field(mul_idx, 4)});
            report_vector(mul_idx);
            mul_pending = 1'b0;
        end
        if (data_req) begin
            if (!held_valid) begin
                $display("data_req raised while execute holds no instruction");
                err_cnt++;
            end
            check("data_addr", data_addr, field(held_idx, 4));
            check("data_wr", data_wr, |c[19:17]);
            check("data_size", data_size, size_of(c[19:12]));
            check("data_wstrb", data_wstrb, c[31:28]);
            if (|c[19:17]) begin
                check("data_wdata", data_wdata, store_data(c[19:12], field(held_idx, 3)));
            end
            req_seen = 1'b1;
            if (data_addr_ok) begin
                req_done = 1'b1;
            end
        end
        if (stall_q && held_valid && held_idx == stall_idx && !flush) begin
            check("mem_out", mem_out, saved_out);
        end
        stall_q   = mem_valid & ~mem_allowin;
        stall_idx = held_idx;
        saved_out = mem_out;
        if (out_xfer) begin
            handed_cnt++;
            check("mem_out.pc", mem_out.pc, pc_of(held_idx));
            check("mem_out.rf_waddr", mem_out.rf_waddr, held_idx[4:0]);
            check("mem_out.ld_op", mem_out.ld_op, c[16:12]);
            check("mem_out.res_sel", mem_out.res_sel, c[22:20]);
            check("mem_out.excep.ale", mem_out.excep.ale, c[27]);
            if (|c[19:12] && !c[27] && !req_done) begin
                $display("instruction %0d left without an accepted memory request", held_idx);
                err_cnt++;
            end
            if (c[27] && req_seen) begin
                $display("misaligned instruction %0d raised a memory request", held_idx);
                err_cnt++;
            end
            if (c[21]) begin
                mul_idx     = held_idx;
                mul_pending = 1'b1;
            end else begin
                check("mem_out.result", mem_out.result, field(held_idx, 4));
                check("fwd.result", fwd.result, field(held_idx, 4));
                report_vector(held_idx);
            end
        end
    endtask

    task automatic advance_state();
        if (flush) begin
            $display("vector %0d flushed", held_idx);
            flush_cnt++;
            done_cnt++;
            held_valid = 1'b0;
        end else if (out_xfer) begin
            held_valid = 1'b0;
        end
        if (in_xfer) begin
            held_idx          = cur_idx;
            held_valid        = 1'b1;
            err_mark[cur_idx] = err_cnt;
            req_seen          = 1'b0;
            req_done          = 1'b0;
            cur_idx++;
        end
    endtask

    initial begin
        logic [31:0] c;
        clk          = 1'b0;
        resetn       = 1'b0;
        id_valid     = 1'b0;
        id_in        = '0;
        mem_allowin  = 1'b0;
        data_addr_ok = 1'b0;
        flush        = 1'b0;
        mem_excep    = 1'b0;
        seed         = 32'h84fe7997;
        err_cnt      = 0;
        done_cnt     = 0;
        handed_cnt   = 0;
        flush_cnt    = 0;
        cur_idx      = 0;
        held_idx     = 0;
        stall_idx    = 0;
        mul_idx      = 0;
        held_valid   = 1'b0;
        req_seen     = 1'b0;
        req_done     = 1'b0;
        stall_q      = 1'b0;
        mul_pending  = 1'b0;
        $readmemh("tb/ex_vectors.mem", vec);
        nvec  = 0;
        nflag = 0;
        while (nvec < MAX_VEC && !$isunknown(vec[nvec*WORDS])) begin
            c = field(nvec, 0);
            nflag += c[26];
            nvec++;
        end
        if (nvec == 0) begin
            $display("no vectors could be read from tb/ex_vectors.mem");
            err_cnt++;
        end
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b1;
        drive_inputs();
        while (done_cnt < nvec) begin
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
            advance_state();
            #1;
            drive_inputs();
        end
        check("instructions handed to memory", handed_cnt, nvec - nflag);
        $display("%0d vectors, %0d handed on, %0d flushed, %0d errors",
                 nvec, handed_cnt, flush_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // bound grows with the vector count
    initial begin
        @(posedge resetn);
        repeat (nvec * 60 + 200) @(posedge clk);
        $display("timeout: not every vector left the execute stage in time");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
